//--- dv/testdata.txt
# a0 a1 a2 a3 b0 b1 b2 b3 expected, 17-bit hex, 8 fraction bits
# expected is the sum over lanes of (a * b) >>> 8, products and sum wrapped to 17 bits
00100 00200 00300 00400 00100 00100 00100 00100 00A00
00080 00040 00180 1FF00 00200 00400 00200 00300 00200
1FE00 1FF80 00300 00000 00180 1FC00 1FD80 00700 1F780
00001 00003 1FFFF 00030 00001 00055 00001 00030 00008
00180 1FE80 000FF 1FF01 00155 00155 000FF 000FF 1FFFE
0FFFF 00100 00000 00000 0FFFF 00100 00000 00000 1FF00
07F00 07F00 07F00 07F00 00100 00100 00100 00100 1FC00
10000 10000 00100 00000 00100 00100 00300 00000 00300
10000 10000 00200 00000 10000 1FF00 00300 00000 10600
04000 02000 1FF00 00080 00800 00300 1FF00 1FF00 06080
00123 1FEDD 00010 1FFF0 00201 00201 00020 00020 1FFFF
00000 00000 00000 00000 00000 00000 00000 00000 00000
00001 00002 00003 00004 0FFFF 0FFFF 0FFFF 0FFFF 009FC
1FF80 00080 1FFC0 00020 1FF80 1FF80 00040 00020 1FFF4
1FFFF 1FFFF 1FFFF 1FFFF 00001 00002 000FF 00100 1FFFC

//--- files.f
logic/fixPkg.sv
logic/fixPu.sv
logic/fixSum.sv
logic/dotProduct.sv
logic/axiLiteRegs.sv
logic/dotTop.sv
dv/dotTop_chk.sv
dv/dotTb.sv

//--- run.sh
#!/bin/sh
# Build and run the dot-product testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dotTb -f files.f -o dotSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dotSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the verdict
if grep -q "^Test passed$" "$LOG"; then
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi

//--- dv/dotTb.sv
`timescale 1ns/1ps

module dotTb;
    import fixPkg::*;

    localparam int MAX_LINES = 32;

    logic      clk;
    logic      reset;
    axiLiteReq req;
    axiLiteRsp rsp;

    int seed       = 14;
    int cycles     = 0;
    int cycleLimit = 500;
    int lineCount  = 0;

    logic [N_TOT:0] aLane[MAX_LINES][VEC_LEN];
    logic [N_TOT:0] bLane[MAX_LINES][VEC_LEN];
    logic [N_TOT:0] expected[MAX_LINES];

    dotTop dut (.clk(clk), .reset(reset), .req(req), .rsp(rsp));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, a response or the done flag never came", cycles);
            $display("Test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic compareValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Register value as the host sees it, 17 bits sign-extended to 32
    function automatic logic [DATA_W-1:0] extendLane(logic [N_TOT:0] value);
        logic signed [DATA_W-1:0] word;
        word = $signed(value);
        return word;
    endfunction

    // All bus tasks start and end at a falling edge
    task automatic sendWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        bit awDone;
        bit wDone;
        awDone      = 1'b0;
        wDone       = 1'b0;
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wvalid  = 1'b1;
        while (!(awDone && wDone)) begin
            if (req.awvalid && rsp.awready) awDone = 1'b1;
            if (req.wvalid && rsp.wready) wDone = 1'b1;
            @(negedge clk);
            if (awDone) req.awvalid = 1'b0;
            if (wDone) req.wvalid = 1'b0;
        end
    endtask

    task automatic takeResponse(output axiResp resp);
        int delay;
        while (!rsp.bvalid) begin
            @(negedge clk);
        end
        delay = {$random(seed)} % 4;
        repeat (delay) @(negedge clk);
        resp       = rsp.bresp;
        req.bready = 1'b1;
        @(negedge clk);
        req.bready = 1'b0;
    endtask

    task automatic writeReg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input axiResp expResp);
        axiResp resp;
        sendWrite(addr, data);
        takeResponse(resp);
        compareValue("bresp", 32'(expResp), 32'(resp));
    endtask

    task automatic readReg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output axiResp resp);
        int delay;
        req.araddr  = addr;
        req.arvalid = 1'b1;
        while (!rsp.arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        req.arvalid = 1'b0;
        while (!rsp.rvalid) begin
            @(negedge clk);
        end
        // A pending read response blocks the address channel
        compareValue("arready while rvalid", 32'h0, 32'(rsp.arready));
        delay = {$random(seed)} % 4;
        repeat (delay) @(negedge clk);
        data       = rsp.rdata;
        resp       = rsp.rresp;
        req.rready = 1'b1;
        @(negedge clk);
        req.rready = 1'b0;
    endtask

    task automatic readExpect(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expData,
                              input axiResp expResp, input string name);
        logic [DATA_W-1:0] data;
        axiResp            resp;
        readReg(addr, data, resp);
        compareValue({name, " rdata"}, expData, data);
        compareValue({name, " rresp"}, 32'(expResp), 32'(resp));
    endtask

    task automatic readTestData();
        int    fd;
        int    count;
        string line;
        fd = $fopen("dv/testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/testdata.txt");
            $display("Test failed");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd) && lineCount < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            aLane[lineCount][0], aLane[lineCount][1], aLane[lineCount][2],
                            aLane[lineCount][3], bLane[lineCount][0], bLane[lineCount][1],
                            bLane[lineCount][2], bLane[lineCount][3], expected[lineCount]);
            if (count != 9) begin
                $display("Stimulus line %0d does not hold nine hex values", lineCount + 1);
                $display("Test failed");
                $fatal(1, "bad stimulus");
            end
            lineCount++;
        end
        $fclose(fd);
        if (lineCount == 0) begin
            $display("The stimulus file holds no test lines");
            $display("Test failed");
            $fatal(1, "empty stimulus");
        end
    endtask

    task automatic loadOperands(input int line);
        for (int i = 0; i < VEC_LEN; i++) begin
            writeReg(ADDR_A_BASE + ADDR_W'(4 * i), DATA_W'(aLane[line][i]), RESP_OKAY);
            writeReg(ADDR_B_BASE + ADDR_W'(4 * i), DATA_W'(bLane[line][i]), RESP_OKAY);
        end
    endtask

    task automatic checkLaneValues(input int line);
        for (int i = 0; i < VEC_LEN; i++) begin
            readExpect(ADDR_A_BASE + ADDR_W'(4 * i), extendLane(aLane[line][i]), RESP_OKAY, "opA");
            readExpect(ADDR_B_BASE + ADDR_W'(4 * i), extendLane(bLane[line][i]), RESP_OKAY, "opB");
        end
    endtask

    task automatic waitDone();
        logic [DATA_W-1:0] status;
        axiResp            resp;
        status = '0;
        while (!status[0]) begin
            readReg(ADDR_STATUS, status, resp);
            compareValue("status rresp", 32'(RESP_OKAY), 32'(resp));
        end
    endtask

    task automatic runLine(input int line);
        loadOperands(line);
        writeReg(ADDR_CTRL, 32'h1, RESP_OKAY);
        waitDone();
        readExpect(ADDR_RESULT, extendLane(expected[line]), RESP_OKAY, "dot result");
    endtask

    task automatic checkLaneReadback();
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] value;
        for (int i = 0; i < 2 * VEC_LEN; i++) begin
            addr  = (i < VEC_LEN ? ADDR_A_BASE : ADDR_B_BASE) + ADDR_W'(4 * (i % VEC_LEN));
            value = $random(seed);
            writeReg(addr, value, RESP_OKAY);
            readExpect(addr, extendLane(value[N_TOT:0]), RESP_OKAY, "lane readback");
        end
    endtask

    task automatic checkUnmapped();
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < 3; i++) begin
            addr = (i == 0) ? 12'h00C : (i == 1) ? 12'h030 : 12'hFFC;
            writeReg(addr, 32'h0001_5A5A, RESP_SLVERR);
            readExpect(addr, '0, RESP_SLVERR, "unmapped read");
        end
    endtask

    // Second write is presented while the first response is still unanswered
    task automatic checkWriteStall();
        axiResp resp;
        sendWrite(ADDR_A_BASE, 32'h0000_0AAA);
        req.awaddr  = ADDR_A_BASE + 12'h004;
        req.awvalid = 1'b1;
        req.wdata   = 32'h0001_0555;
        req.wvalid  = 1'b1;
        repeat (3) begin
            compareValue("bvalid held", 32'h1, 32'(rsp.bvalid));
            compareValue("awready stalled", 32'h0, 32'(rsp.awready));
            compareValue("wready stalled", 32'h0, 32'(rsp.wready));
            @(negedge clk);
        end
        takeResponse(resp);
        compareValue("first bresp", 32'(RESP_OKAY), 32'(resp));
        writeReg(ADDR_A_BASE + 12'h004, 32'h0001_0555, RESP_OKAY);
        readExpect(ADDR_A_BASE, 32'h0000_0AAA, RESP_OKAY, "first stalled write");
        readExpect(ADDR_A_BASE + 12'h004, 32'hFFFF_0555, RESP_OKAY, "second stalled write");
    endtask

    task automatic checkBackToBack(input int first, input int second);
        loadOperands(first);
        writeReg(ADDR_CTRL, 32'h1, RESP_OKAY);
        loadOperands(second);
        writeReg(ADDR_CTRL, 32'h1, RESP_OKAY);
        waitDone();
        readExpect(ADDR_RESULT, extendLane(expected[second]), RESP_OKAY, "second result");
        readExpect(ADDR_STATUS, 32'h1, RESP_OKAY, "done after two starts");
    endtask

    initial begin
        reset = 1'b1;
        req   = '0;
        readTestData();
        cycleLimit = 200 * lineCount + 500;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        readExpect(ADDR_STATUS, '0, RESP_OKAY, "status after reset");
        readExpect(ADDR_CTRL, '0, RESP_OKAY, "control after reset");
        readExpect(ADDR_RESULT, '0, RESP_OKAY, "result after reset");
        checkLaneReadback();
        loadOperands(0);
        checkUnmapped();
        checkLaneValues(0);
        checkWriteStall();
        for (int i = 0; i < lineCount; i++) begin
            runLine(i);
        end
        checkBackToBack(0, lineCount - 1);
        $display("Test passed");
        $finish;
    end

endmodule

//--- dv/dotTop_chk.sv
`timescale 1ns/1ps

module dotTop_chk (
    input logic              clk,
    input logic              reset,
    input fixPkg::axiLiteReq req,
    input fixPkg::axiLiteRsp rsp,
    input logic              start,
    input logic              done
);

    // Master side holds valid and payload until ready
    awHold: assert property (@(posedge clk) disable iff (reset)
        req.awvalid && !rsp.awready |=> req.awvalid && $stable(req.awaddr))
        else $error("write address dropped or changed before awready");

    wHold: assert property (@(posedge clk) disable iff (reset)
        req.wvalid && !rsp.wready |=> req.wvalid && $stable(req.wdata))
        else $error("write data dropped or changed before wready");

    arHold: assert property (@(posedge clk) disable iff (reset)
        req.arvalid && !rsp.arready |=> req.arvalid && $stable(req.araddr))
        else $error("read address dropped or changed before arready");

    // Slave side responses wait for the master
    bHold: assert property (@(posedge clk) disable iff (reset)
        rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
        else $error("write response dropped or changed before bready");

    rHold: assert property (@(posedge clk) disable iff (reset)
        rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata) && $stable(rsp.rresp))
        else $error("read response dropped or changed before rready");

    doneCleared: assert property (@(posedge clk) disable iff (reset) start |=> !done)
        else $error("done still set the cycle after a start");

    quietAfterReset: assert property (@(posedge clk) reset |=> !rsp.bvalid && !rsp.rvalid && !start)
        else $error("slave valid or start active out of reset");

    readyAfterReset: assert property (@(posedge clk)
        reset |=> rsp.awready && rsp.wready && rsp.arready && !done)
        else $error("ready low or done set out of reset");

endmodule

bind dotTop dotTop_chk chk (
    .clk(clk),
    .reset(reset),
    .req(req),
    .rsp(rsp),
    .start(start),
    .done(regs.done)
);

//--- logic/dotTop.sv
`timescale 1ns/1ps

module dotTop (
    input  logic              clk,
    input  logic              reset,
    input  fixPkg::axiLiteReq req,
    output fixPkg::axiLiteRsp rsp
);
    import fixPkg::*;

    // Operands and start from the register block
    fixVec opA;
    fixVec opB;
    logic  start;

    // Result back from the datapath
    fixNum dotResult;
    logic  resultValid;

    axiLiteRegs regs (
        .clk(clk),
        .reset(reset),
        .req(req),
        .rsp(rsp),
        .opA(opA),
        .opB(opB),
        .start(start),
        .dotResult(dotResult),
        .resultValid(resultValid)
    );

    dotProduct datapath (
        .clk(clk),
        .reset(reset),
        .start(start),
        .opA(opA),
        .opB(opB),
        .dotResult(dotResult),
        .resultValid(resultValid)
    );

endmodule

//--- logic/axiLiteRegs.sv
`timescale 1ns/1ps

module axiLiteRegs (
    input  logic              clk,
    input  logic              reset,
    input  fixPkg::axiLiteReq req,
    output fixPkg::axiLiteRsp rsp,
    output fixPkg::fixVec     opA,
    output fixPkg::fixVec     opB,
    output logic              start,
    input  fixPkg::fixNum     dotResult,
    input  logic              resultValid
);
    import fixPkg::*;

    // Byte address of a lane within an operand bank
    function automatic logic [ADDR_W-1:0] laneAddr(logic [ADDR_W-1:0] base, int lane);
        return base + ADDR_W'(4 * lane);
    endfunction

    function automatic logic [DATA_W-1:0] signExt(fixNum value);
        return {{(DATA_W - N_TOT - 1){value[N_TOT]}}, value};
    endfunction

    function automatic logic isMapped(logic [ADDR_W-1:0] addr);
        logic hit;
        hit = (addr == ADDR_CTRL) || (addr == ADDR_STATUS) || (addr == ADDR_RESULT);
        for (int i = 0; i < VEC_LEN; i++) begin
            if (addr == laneAddr(ADDR_A_BASE, i) || addr == laneAddr(ADDR_B_BASE, i)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    logic              awready;
    logic              wready;
    logic              arready;
    logic              awFire;
    logic              wFire;
    logic              arFire;
    logic              awHeld;
    logic              wHeld;
    logic [ADDR_W-1:0] awAddrQ;
    logic [DATA_W-1:0] wDataQ;
    logic [ADDR_W-1:0] wrAddr;
    logic [DATA_W-1:0] wrData;
    logic              doWrite;
    logic              wrMapped;
    logic              startNext;
    logic              bvalid;
    axiResp            bresp;
    logic              rvalid;
    axiResp            rresp;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] rdNext;
    logic              rdMapped;
    logic              done;
    fixNum             resultQ;

    // A held beat or a pending response blocks the write channels
    assign awready = !awHeld && !bvalid;
    assign wready  = !wHeld && !bvalid;
    assign arready = !rvalid;

    assign awFire = req.awvalid && awready;
    assign wFire  = req.wvalid && wready;
    assign arFire = req.arvalid && arready;

    // Use the held beat if it came first, else the one on the bus
    assign wrAddr  = awHeld ? awAddrQ : req.awaddr;
    assign wrData  = wHeld ? wDataQ : req.wdata;
    assign doWrite = (awHeld || awFire) && (wHeld || wFire);

    assign wrMapped  = isMapped(wrAddr);
    assign startNext = doWrite && (wrAddr == ADDR_CTRL) && wrData[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            awHeld <= 1'b0;
            wHeld  <= 1'b0;
            bvalid <= 1'b0;
        end else if (doWrite) begin
            awHeld <= 1'b0;
            wHeld  <= 1'b0;
            bvalid <= 1'b1;
        end else begin
            if (awFire) begin
                awHeld <= 1'b1;
            end
            if (wFire) begin
                wHeld <= 1'b1;
            end
            if (bvalid && req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awFire) begin
            awAddrQ <= req.awaddr;
        end
        if (wFire) begin
            wDataQ <= req.wdata;
        end
        if (doWrite) begin
            bresp <= wrMapped ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Operand, control and result registers
    always_ff @(posedge clk) begin
        if (reset) begin
            opA     <= '0;
            opB     <= '0;
            start   <= 1'b0;
            done    <= 1'b0;
            resultQ <= '0;
        end else begin
            start <= startNext;
            if (doWrite) begin
                for (int i = 0; i < VEC_LEN; i++) begin
                    if (wrAddr == laneAddr(ADDR_A_BASE, i)) begin
                        opA[i] <= wrData[N_TOT:0];
                    end
                    if (wrAddr == laneAddr(ADDR_B_BASE, i)) begin
                        opB[i] <= wrData[N_TOT:0];
                    end
                end
            end
            if (resultValid) begin
                resultQ <= dotResult;
            end
            // A new start wins over a result still draining from the pipeline
            if (startNext || start) begin
                done <= 1'b0;
            end else if (resultValid) begin
                done <= 1'b1;
            end
        end
    end

    // Read mux, control and unmapped addresses read zero
    always_comb begin
        rdNext   = '0;
        rdMapped = isMapped(req.araddr);
        if (req.araddr == ADDR_STATUS) begin
            rdNext = {{(DATA_W - 1){1'b0}}, done};
        end else if (req.araddr == ADDR_RESULT) begin
            rdNext = signExt(resultQ);
        end else begin
            for (int i = 0; i < VEC_LEN; i++) begin
                if (req.araddr == laneAddr(ADDR_A_BASE, i)) begin
                    rdNext = signExt(opA[i]);
                end
                if (req.araddr == laneAddr(ADDR_B_BASE, i)) begin
                    rdNext = signExt(opB[i]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (arFire) begin
            rvalid <= 1'b1;
        end else if (rvalid && req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arFire) begin
            rdata <= rdNext;
            rresp <= rdMapped ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_comb begin
        rsp.awready = awready;
        rsp.wready  = wready;
        rsp.bresp   = bresp;
        rsp.bvalid  = bvalid;
        rsp.arready = arready;
        rsp.rdata   = rdata;
        rsp.rresp   = rresp;
        rsp.rvalid  = rvalid;
    end

endmodule

//--- logic/dotProduct.sv
`timescale 1ns/1ps

module dotProduct (
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    input  fixPkg::fixVec opA,
    input  fixPkg::fixVec opB,
    output fixPkg::fixNum dotResult,
    output logic          resultValid
);
    import fixPkg::*;

    fixNum laneProd[VEC_LEN];
    fixNum prodReg[VEC_LEN];

    // One bit per pipeline stage, several computations may be in flight
    logic [DOT_LATENCY-1:0] validPipe;

    for (genvar i = 0; i < VEC_LEN; i++) begin : gLane
        fixPu #(.op(FPU_MULT)) mult (
            .a(opA[i]),
            .b(opB[i]),
            .result(laneProd[i])
        );
    end

    // Products are taken at start so later operand writes do not disturb the run
    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < VEC_LEN; i++) begin
                prodReg[i] <= laneProd[i];
            end
        end
    end

    fixSum #(
        .size(VEC_LEN),
        .addersComb(ADDERS_COMB)
    ) tree (
        .clk(clk),
        .terms(prodReg),
        .sum(dotResult)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[DOT_LATENCY-2:0], start};
        end
    end

    assign resultValid = validPipe[DOT_LATENCY-1];

endmodule

//--- logic/fixSum.sv
`timescale 1ns/1ps

module fixSum #(
    parameter int size       = 2,
    parameter int addersComb = 1
) (
    input  logic          clk,
    input  fixPkg::fixNum terms[size],
    output fixPkg::fixNum sum
);
    import fixPkg::*;

    // Number of terms that enter layer n
    function automatic int termsIn(int n);
        int count;
        count = size;
        for (int i = 0; i < n; i++) begin
            count = (count + 1) / 2;
        end
        return count;
    endfunction

    // One adder per neighbour pair in layer n
    function automatic int adderCount(int n);
        return termsIn(n) / 2;
    endfunction

    // Outputs of layer n, an odd last term rides along unchanged
    function automatic int regCount(int n);
        return (termsIn(n) + 1) / 2;
    endfunction

    // First node feeding layer n; the input terms fill the lowest nodes
    function automatic int firstNode(int n);
        int index;
        index = 0;
        for (int i = 0; i < n; i++) begin
            index += termsIn(i);
        end
        return index;
    endfunction

    localparam int layers = $clog2(size);
    localparam int nodes  = firstNode(layers) + 1;

    fixNum node[nodes];

    for (genvar t = 0; t < size; t++) begin : gInput
        assign node[t] = terms[t];
    end

    // With a single term there are no layers and the input goes straight out
    for (genvar l = 0; l < layers; l++) begin : gLayer
        localparam int inBase  = firstNode(l);
        localparam int outBase = firstNode(l + 1);
        localparam int adders  = adderCount(l);
        localparam int outs    = regCount(l);

        for (genvar j = 0; j < outs; j++) begin : gNode
            fixNum layerOut;

            if (j < adders) begin : gAdd
                fixPu #(.op(FPU_ADD)) adder (
                    .a(node[inBase + 2*j]),
                    .b(node[inBase + 2*j + 1]),
                    .result(layerOut)
                );
            end else begin : gPass
                assign layerOut = node[inBase + 2*j];
            end

            // Register every addersComb layers to cut the adder chain
            if ((l + 1) % addersComb == 0) begin : gReg
                always_ff @(posedge clk) begin
                    node[outBase + j] <= layerOut;
                end
            end else begin : gComb
                assign node[outBase + j] = layerOut;
            end
        end
    end

    assign sum = node[nodes - 1];

endmodule

//--- logic/fixPu.sv
`timescale 1ns/1ps

module fixPu #(
    parameter fixPkg::fpuOp op = fixPkg::FPU_ADD
) (
    input  fixPkg::fixNum a,
    input  fixPkg::fixNum b,
    output fixPkg::fixNum result
);
    import fixPkg::*;

    if (op == FPU_ADD) begin : gAdd
        // Wraps at the number width
        assign result = a + b;
    end else begin : gMult
        // Full product carries twice the fraction bits
        logic signed [2*N_TOT+1:0] product;

        assign product = a * b;
        // Arithmetic shift floors toward minus infinity before the cut to width
        assign result = fixNum'(product >>> N_MANT);
    end

endmodule

//--- logic/fixPkg.sv
package fixPkg;

    // Sign plus integer and fraction bits
    localparam int N_INT  = 8;
    localparam int N_MANT = 8;
    localparam int N_TOT  = N_INT + N_MANT;

    typedef logic signed [N_TOT:0] fixNum;

    // Vector length and adder tree shape
    localparam int VEC_LEN     = 4;
    localparam int ADDERS_COMB = 1;
    localparam int SUM_LAYERS  = $clog2(VEC_LEN);

    // Product register plus the tree registers
    localparam int DOT_LATENCY = 1 + SUM_LAYERS / ADDERS_COMB;

    typedef enum logic {
        FPU_ADD,
        FPU_MULT
    } fpuOp;

    // Bus widths
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    // Register map, byte addresses
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 12'h004;
    localparam logic [ADDR_W-1:0] ADDR_RESULT = 12'h008;
    // Lanes sit four bytes apart from these bases
    localparam logic [ADDR_W-1:0] ADDR_A_BASE = 12'h010;
    localparam logic [ADDR_W-1:0] ADDR_B_BASE = 12'h020;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axiResp;

    // Fields driven by the AXI4-Lite master
    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic              awvalid;
        logic [DATA_W-1:0] wdata;
        logic              wvalid;
        logic              bready;
        logic [ADDR_W-1:0] araddr;
        logic              arvalid;
        logic              rready;
    } axiLiteReq;

    // Fields driven by the AXI4-Lite slave
    typedef struct packed {
        logic              awready;
        logic              wready;
        axiResp            bresp;
        logic              bvalid;
        logic              arready;
        logic [DATA_W-1:0] rdata;
        axiResp            rresp;
        logic              rvalid;
    } axiLiteRsp;

    // One operand per lane
    typedef fixNum [VEC_LEN-1:0] fixVec;

endpackage
